/* rtl/rename_defs.svh */
// Sizes shared by the renamer RTL
// The depths are tied to 32 architectural registers on 64 physical ones
// Changing one count means rechecking the init sequence and the FIFO depths
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural integer registers
`define ARCH_REGS 32

// Physical registers behind them
`define PHYS_REGS 64

// Address widths
`define ARCH_AW 5
`define PHYS_AW 6

// Free list and in-use list depth
// Equals the number of physical registers not mapped after init
`define INFLIGHT_DEPTH 32

`endif

/* rtl/rename_pkg.sv */
// Types shared by the renamer blocks and the testbench
// Widths come from the defines header

`include "rename_defs.svh"

package rename_pkg;

    // Architectural register number
    typedef logic [`ARCH_AW-1:0] arch_addr_t;

    // Physical register number
    typedef logic [`PHYS_AW-1:0] phys_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // In-use list entry
    ////////////////////////////////////////////////////////////////////////////
    // One issued destination waiting for retire
    // spec_phys is freed on a suppress and prev_phys on a commit
    typedef struct packed {
        arch_addr_t rd;
        phys_addr_t spec_phys;
        phys_addr_t prev_phys;
    } inuse_entry_t;

endpackage

/* rtl/rename_ifs.sv */
// Internal links between the renamer blocks
// Both bundles are combinational and carry no handshake

//////////////////////////////////////////////////////////////////////////////
// Qualified events from the control block
//////////////////////////////////////////////////////////////////////////////
interface rename_ctrl_if import rename_pkg::*; ();

    // Post-reset init walk
    logic       init_active;
    arch_addr_t init_index;

    // Events already gated by ready
    logic       rename_valid;
    logic       rollback;
    logic       restore;

    // Raw flush, clears the restore-once bits
    logic       flush;

    modport ctrl (
        output init_active, init_index, rename_valid, rollback, restore, flush
    );

    modport free_side (
        input init_active, init_index, rename_valid, rollback
    );

    modport map_side (
        input init_active, init_index, rename_valid, rollback, restore, flush
    );

endinterface

//////////////////////////////////////////////////////////////////////////////
// Retire view of the in-use list head
//////////////////////////////////////////////////////////////////////////////
interface retire_if import rename_pkg::*; ();

    logic         retire_valid;
    logic         suppress;
    inuse_entry_t entry;
    logic         empty;

    modport source    (output retire_valid, suppress, entry, empty);
    modport free_side (input retire_valid, suppress, entry);
    // Map side only needs the entry, restore comes qualified from control
    modport map_side  (input entry);
    modport ctrl_side (input retire_valid, empty);

endinterface

/* rtl/rename_ctrl.sv */
// Control block of the renamer
// Walks 32 init cycles after reset, then raises ready for good
// Every event is dropped while ready is low

`include "rename_defs.svh"

module rename_ctrl import rename_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rename_req,
    input  logic       flush,
    input  logic       issue_valid,
    input  logic       suppress,
    input  logic       retire_valid,
    input  arch_addr_t rd_addr,
    input  arch_addr_t issue_rd_addr,
    output logic       ready,
    rename_ctrl_if.ctrl ctrl,
    retire_if.ctrl_side ret
);

    // Top bit set once all entries are written
    logic [`ARCH_AW:0] init_cnt;
    logic              ready_q;
    logic              last_init;

    ////////////////////////////////////////////////////////////////////////////
    // Init counter and ready flag
    ////////////////////////////////////////////////////////////////////////////
    assign ctrl.init_active = !init_cnt[`ARCH_AW];
    assign ctrl.init_index  = init_cnt[`ARCH_AW-1:0];
    assign last_init = ctrl.init_active && (ctrl.init_index == arch_addr_t'(`ARCH_REGS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_cnt <= '0;
        end else if (ctrl.init_active) begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    // Rises the cycle after the last map write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= 1'b0;
        end else if (last_init) begin
            ready_q <= 1'b1;
        end
    end

    assign ready = ready_q;

    ////////////////////////////////////////////////////////////////////////////
    // Event qualification
    ////////////////////////////////////////////////////////////////////////////
    // Register zero is never renamed
    assign ctrl.rename_valid = ready_q && rename_req && !flush && (rd_addr != '0);

    // Renamed destination flushed while sitting at issue
    assign ctrl.rollback = ready_q && flush && issue_valid && (issue_rd_addr != '0);

    // Discarded instruction at retire
    assign ctrl.restore = ready_q && retire_valid && suppress;

    assign ctrl.flush = flush;

    // Retire must match an issued destination
    a_retire_not_empty: assert property (
        @(posedge clk) disable iff (!arst_n) ret.retire_valid |-> !ret.empty
    ) else $error("retire with empty in-use list");

endmodule

/* rtl/free_list.sv */
// Circular FIFO of free physical registers
// Loaded with registers 32 to 63 during init
// No back-pressure exists, overflow and underflow only trip assertions

`include "rename_defs.svh"

module free_list import rename_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    rename_ctrl_if.free_side ctrl,
    retire_if.free_side ret,
    output phys_addr_t head
);

    localparam int IDX_W = $clog2(`INFLIGHT_DEPTH);

    phys_addr_t     mem [`INFLIGHT_DEPTH];
    // Pointers carry one wrap bit for full/empty
    logic [IDX_W:0] rd_ptr;
    logic [IDX_W:0] wr_ptr;
    logic [IDX_W:0] count;
    logic           push;
    logic           pop;
    logic           empty;
    logic           full;
    phys_addr_t     push_data;

    assign push = ctrl.init_active || ret.retire_valid;
    assign pop  = ctrl.rename_valid;

    // Init pushes the upper half, retire frees old or new register
    always_comb begin
        if (ctrl.init_active) begin
            push_data = phys_addr_t'(`PHYS_REGS - `INFLIGHT_DEPTH) + phys_addr_t'(ctrl.init_index);
        end else if (ret.suppress) begin
            push_data = ret.entry.spec_phys;
        end else begin
            push_data = ret.entry.prev_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[IDX_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Rollback hands the last popped register back
    // It never coincides with a pop since rename needs flush low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (ctrl.rollback) begin
            rd_ptr <= rd_ptr - 1'b1;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign count = wr_ptr - rd_ptr;
    assign empty = (count == '0);
    assign full  = count[IDX_W];
    assign head  = mem[rd_ptr[IDX_W-1:0]];

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) pop |-> !empty
    ) else $error("free list popped while empty");

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> !full
    ) else $error("free list pushed while full");

endmodule

/* rtl/spec_map_table.sv */
// Speculative architectural-to-physical map
// Single write port, priority init then rollback then restore then rename
// Issue must follow its rename before the next map write for prev_phys to hold

`include "rename_defs.svh"

module spec_map_table import rename_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    rename_ctrl_if.map_side ctrl,
    retire_if.map_side ret,
    input  arch_addr_t rd_addr,
    input  arch_addr_t rs1_addr,
    input  arch_addr_t rs2_addr,
    input  arch_addr_t issue_rd_addr,
    input  phys_addr_t new_phys,
    output phys_addr_t phys_rs1,
    output phys_addr_t phys_rs2,
    output phys_addr_t prev_phys
);

    phys_addr_t             map [`ARCH_REGS];
    // Set once an entry was restored since the last flush
    logic [`ARCH_REGS-1:0]  restored;
    phys_addr_t             prev_q;
    logic                   restore_en;
    logic                   map_write;
    arch_addr_t             wr_idx;
    phys_addr_t             wr_data;

    ////////////////////////////////////////////////////////////////////////////
    // Write selection
    ////////////////////////////////////////////////////////////////////////////
    // Only the oldest suppressed write of a register may restore it
    // Later ones would bring back an intermediate mapping
    assign restore_en = ctrl.restore && !restored[ret.entry.rd];

    assign map_write = ctrl.init_active || ctrl.rollback || restore_en || ctrl.rename_valid;

    always_comb begin
        if (ctrl.init_active) begin
            // Identity map for the lower half
            wr_idx  = ctrl.init_index;
            wr_data = phys_addr_t'(ctrl.init_index);
        end else if (ctrl.rollback) begin
            wr_idx  = issue_rd_addr;
            wr_data = prev_q;
        end else if (restore_en) begin
            wr_idx  = ret.entry.rd;
            wr_data = ret.entry.prev_phys;
        end else begin
            wr_idx  = rd_addr;
            wr_data = new_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (map_write) begin
            map[wr_idx] <= wr_data;
        end
    end

    // Old mapping of the register being written, consumed at issue
    always_ff @(posedge clk) begin
        if (map_write) begin
            prev_q <= map[wr_idx];
        end
    end

    assign prev_phys = prev_q;

    ////////////////////////////////////////////////////////////////////////////
    // Restore-once bits
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            restored <= '0;
        end else if (ctrl.flush) begin
            restored <= '0;
        end else if (ctrl.restore) begin
            restored[ret.entry.rd] <= 1'b1;
        end
    end

    // Source lookups
    assign phys_rs1 = map[rs1_addr];
    assign phys_rs2 = map[rs2_addr];

    // Zero must stay on physical zero through rename, rollback and restore
    a_zero_mapping: assert property (
        @(posedge clk) disable iff (!arst_n) !ctrl.init_active |-> (map[0] == '0)
    ) else $error("architectural zero remapped");

endmodule

/* rtl/inuse_list.sv */
// FIFO of issued destinations in program order
// Head is presented to retire every cycle
// Pop on empty is checked in the control block

`include "rename_defs.svh"

module inuse_list import rename_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       issued,
    input  arch_addr_t issue_rd_addr,
    input  phys_addr_t issue_phys_rd,
    input  phys_addr_t prev_phys,
    input  logic       retire_valid,
    input  logic       suppress,
    retire_if.source   ret
);

    localparam int IDX_W = $clog2(`INFLIGHT_DEPTH);

    inuse_entry_t   mem [`INFLIGHT_DEPTH];
    logic [IDX_W:0] rd_ptr;
    logic [IDX_W:0] wr_ptr;
    logic [IDX_W:0] count;
    logic           push;
    inuse_entry_t   push_entry;

    // Register zero has nothing to free
    assign push = issued && (issue_rd_addr != '0);

    assign push_entry.rd        = issue_rd_addr;
    assign push_entry.spec_phys = issue_phys_rd;
    assign push_entry.prev_phys = prev_phys;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[IDX_W-1:0]] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (retire_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign count = wr_ptr - rd_ptr;

    // Retire view
    assign ret.retire_valid = retire_valid;
    assign ret.suppress     = suppress;
    assign ret.entry        = mem[rd_ptr[IDX_W-1:0]];
    assign ret.empty        = (count == '0);

    // More than 32 in flight breaks the no-stall assumption
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> !count[IDX_W]
    ) else $error("in-use list pushed while full");

endmodule

/* rtl/register_renamer.sv */
// Register renamer top level
// 32 architectural integer registers on 64 physical ones
// Renames never stall, at most 32 destinations may be in flight
// Inputs are plain strobes sampled on the rising clock edge

module register_renamer (
    input  logic                   clk,
    input  logic                   arst_n,
    // Decode
    input  logic                   rename_req,
    input  rename_pkg::arch_addr_t rd_addr,
    input  rename_pkg::arch_addr_t rs1_addr,
    input  rename_pkg::arch_addr_t rs2_addr,
    output rename_pkg::phys_addr_t phys_rd,
    output rename_pkg::phys_addr_t phys_rs1,
    output rename_pkg::phys_addr_t phys_rs2,
    // Issue and flush
    input  logic                   flush,
    input  logic                   issue_valid,
    input  logic                   issued,
    input  rename_pkg::arch_addr_t issue_rd_addr,
    input  rename_pkg::phys_addr_t issue_phys_rd,
    // Retire
    input  logic                   retire_valid,
    input  logic                   suppress,
    output logic                   ready
);

    rename_pkg::phys_addr_t free_head;
    rename_pkg::phys_addr_t prev_phys;

    rename_ctrl_if ctrl_bus ();
    retire_if      retire_bus ();

    rename_ctrl u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .rename_req    (rename_req),
        .flush         (flush),
        .issue_valid   (issue_valid),
        .suppress      (suppress),
        .retire_valid  (retire_valid),
        .rd_addr       (rd_addr),
        .issue_rd_addr (issue_rd_addr),
        .ready         (ready),
        .ctrl          (ctrl_bus.ctrl),
        .ret           (retire_bus.ctrl_side)
    );

    free_list u_free_list (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl_bus.free_side),
        .ret    (retire_bus.free_side),
        .head   (free_head)
    );

    spec_map_table u_map (
        .clk           (clk),
        .arst_n        (arst_n),
        .ctrl          (ctrl_bus.map_side),
        .ret           (retire_bus.map_side),
        .rd_addr       (rd_addr),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .issue_rd_addr (issue_rd_addr),
        .new_phys      (free_head),
        .phys_rs1      (phys_rs1),
        .phys_rs2      (phys_rs2),
        .prev_phys     (prev_phys)
    );

    inuse_list u_inuse (
        .clk           (clk),
        .arst_n        (arst_n),
        .issued        (issued),
        .issue_rd_addr (issue_rd_addr),
        .issue_phys_rd (issue_phys_rd),
        .prev_phys     (prev_phys),
        .retire_valid  (retire_valid),
        .suppress      (suppress),
        .ret           (retire_bus.source)
    );

    // Register zero always maps to physical zero
    assign phys_rd = (rd_addr != '0) ? free_head : '0;

endmodule

/* verification/tb_register_renamer.sv */
// Directed testbench for the register renamer
// A reference map, free-list queue and in-use queue follow the renaming rules
// Issue of a destination always follows its rename before any other map write
// Register numbers are random from a fixed seed

`include "rename_defs.svh"

module tb_register_renamer import rename_pkg::*; ();

    // Tests need about 630 cycles, the limit leaves roughly three times that
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       arst_n;
    logic       rename_req;
    arch_addr_t rd_addr;
    arch_addr_t rs1_addr;
    arch_addr_t rs2_addr;
    phys_addr_t phys_rd;
    phys_addr_t phys_rs1;
    phys_addr_t phys_rs2;
    logic       flush;
    logic       issue_valid;
    logic       issued;
    arch_addr_t issue_rd_addr;
    phys_addr_t issue_phys_rd;
    logic       retire_valid;
    logic       suppress;
    logic       ready;

    // Reference model state
    phys_addr_t            ref_map [`ARCH_REGS];
    phys_addr_t            free_q[$];
    inuse_entry_t          inuse_q[$];
    phys_addr_t            ref_prev;
    phys_addr_t            last_alloc;
    logic [`ARCH_REGS-1:0] ref_restored;

    int error_count;
    int check_count;
    int cycle_count;

    register_renamer UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_phys(input string name, input phys_addr_t exp, input phys_addr_t act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    function automatic arch_addr_t random_reg();
        // Never register zero
        return arch_addr_t'($urandom_range(`ARCH_REGS - 1, 1));
    endfunction

    // Reads two map entries and compares both with the model
    task automatic read_check(input arch_addr_t a, input arch_addr_t b, output phys_addr_t got_a);
        @(posedge clk);
        rs1_addr <= a;
        rs2_addr <= b;
        @(negedge clk);
        check_phys($sformatf("phys_rs1 for x%0d", a), ref_map[a], phys_rs1);
        check_phys($sformatf("phys_rs2 for x%0d", b), ref_map[b], phys_rs2);
        got_a = phys_rs1;
    endtask

    task automatic check_map_all();
        phys_addr_t unused;
        for (int i = 0; i < `ARCH_REGS; i += 2) begin
            read_check(arch_addr_t'(i), arch_addr_t'(i + 1), unused);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Operations, each one clock edge, checked against the model
    ////////////////////////////////////////////////////////////////////////////
    task automatic rename_one(input arch_addr_t rd, input arch_addr_t rs1, input arch_addr_t rs2,
                              output phys_addr_t got);
        phys_addr_t exp_rd;
        // Head of the free list, zero for register zero
        exp_rd = (rd != '0) ? free_q[0] : '0;
        @(posedge clk);
        rename_req <= 1'b1;
        rd_addr    <= rd;
        rs1_addr   <= rs1;
        rs2_addr   <= rs2;
        @(negedge clk);
        // Sources see the map before this rename
        check_phys("phys_rd", exp_rd, phys_rd);
        check_phys("phys_rs1", ref_map[rs1], phys_rs1);
        check_phys("phys_rs2", ref_map[rs2], phys_rs2);
        got = phys_rd;
        @(posedge clk);
        rename_req <= 1'b0;
        if (rd != '0) begin
            ref_prev    = ref_map[rd];
            last_alloc  = free_q.pop_front();
            ref_map[rd] = last_alloc;
        end
    endtask

    task automatic issue_one(input arch_addr_t rd, input phys_addr_t phys);
        inuse_entry_t ent;
        @(posedge clk);
        issued        <= 1'b1;
        issue_valid   <= 1'b1;
        issue_rd_addr <= rd;
        issue_phys_rd <= phys;
        @(posedge clk);
        issued      <= 1'b0;
        issue_valid <= 1'b0;
        ent.rd        = rd;
        ent.spec_phys = phys;
        ent.prev_phys = ref_prev;
        if (rd != '0) begin
            inuse_q.push_back(ent);
        end
    endtask

    task automatic retire_one(input logic supp);
        inuse_entry_t ent;
        ent = inuse_q.pop_front();
        @(posedge clk);
        retire_valid <= 1'b1;
        suppress     <= supp;
        @(posedge clk);
        retire_valid <= 1'b0;
        suppress     <= 1'b0;
        if (supp) begin
            free_q.push_back(ent.spec_phys);
            // Only the first suppress since the last flush restores
            if (!ref_restored[ent.rd]) begin
                ref_prev        = ref_map[ent.rd];
                ref_map[ent.rd] = ent.prev_phys;
            end
            ref_restored[ent.rd] = 1'b1;
        end else begin
            free_q.push_back(ent.prev_phys);
        end
    endtask

    task automatic retire_all(input logic supp);
        while (inuse_q.size() != 0) begin
            retire_one(supp);
        end
    endtask

    // Register zero at issue gives a plain flush with no rollback
    task automatic flush_with_issue(input arch_addr_t rd);
        phys_addr_t cur;
        @(posedge clk);
        flush         <= 1'b1;
        issue_valid   <= 1'b1;
        issue_rd_addr <= rd;
        @(posedge clk);
        flush       <= 1'b0;
        issue_valid <= 1'b0;
        ref_restored = '0;
        if (rd != '0) begin
            cur         = ref_map[rd];
            ref_map[rd] = ref_prev;
            ref_prev    = cur;
            free_q.push_front(last_alloc);
        end
    endtask

    task automatic rename_issue_n(input int n);
        arch_addr_t rd;
        phys_addr_t got;
        for (int i = 0; i < n; i++) begin
            rd = random_reg();
            rename_one(rd, random_reg(), random_reg(), got);
            issue_one(rd, got);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic init_sequence();
        int init_wait;
        init_wait = 0;
        for (int k = 0; k < `ARCH_REGS; k++) begin
            ref_map[k] = phys_addr_t'(k);
            free_q.push_back(phys_addr_t'(`PHYS_REGS - `INFLIGHT_DEPTH + k));
        end
        ref_restored = '0;
        while (ready !== 1'b1) begin
            @(negedge clk);
            init_wait++;
        end
        // 32 init writes, ready in the following cycle
        check_count++;
        assert (init_wait == `ARCH_REGS + 1) else begin
            error_count++;
            $display("error at %0t: ready expected after %0d cycles, got %0d",
                     $time, `ARCH_REGS + 1, init_wait);
        end
        check_map_all();
    endtask

    task automatic rename_allocation();
        arch_addr_t rd;
        arch_addr_t prev_rd;
        phys_addr_t got;
        phys_addr_t head_before;
        prev_rd = '0;
        for (int i = 0; i < 6; i++) begin
            rd = random_reg();
            // rs1 reads the destination renamed just before
            rename_one(rd, prev_rd, random_reg(), got);
            check_phys("phys_rd allocation order", phys_addr_t'(`INFLIGHT_DEPTH + i), got);
            issue_one(rd, got);
            prev_rd = rd;
        end
        head_before = free_q[0];
        rename_one('0, prev_rd, random_reg(), got);
        rd = random_reg();
        rename_one(rd, random_reg(), random_reg(), got);
        check_phys("phys_rd after zero rename", head_before, got);
        issue_one(rd, got);
        retire_all(1'b0);
        check_map_all();
    endtask

    task automatic commit_reuse();
        phys_addr_t freed[$];
        arch_addr_t rd;
        phys_addr_t got;
        rename_issue_n(`INFLIGHT_DEPTH);
        foreach (inuse_q[i]) begin
            freed.push_back(inuse_q[i].prev_phys);
        end
        retire_all(1'b0);
        // Free list now holds only the committed old mappings
        for (int i = 0; i < 8; i++) begin
            rd = random_reg();
            rename_one(rd, random_reg(), random_reg(), got);
            check_phys("phys_rd reuse after commit", freed[i], got);
            issue_one(rd, got);
        end
        retire_all(1'b0);
    endtask

    task automatic rollback_reissue();
        arch_addr_t rd;
        arch_addr_t rd_next;
        phys_addr_t old_map;
        phys_addr_t first;
        phys_addr_t got;
        rd = random_reg();
        old_map = ref_map[rd];
        rename_one(rd, rd, random_reg(), got);
        // Register handed out to the flushed rename
        first = last_alloc;
        flush_with_issue(rd);
        // Old mapping is back
        read_check(rd, random_reg(), got);
        check_phys("phys_rs1 after rollback", old_map, got);
        // The flushed register is handed out again
        rd_next = random_reg();
        rename_one(rd_next, rd, random_reg(), got);
        check_phys("phys_rd after rollback", first, got);
        issue_one(rd_next, got);
        retire_all(1'b0);
        check_map_all();
    endtask

    task automatic suppress_restore();
        arch_addr_t rd;
        phys_addr_t orig;
        phys_addr_t p;
        phys_addr_t got;
        rd = random_reg();
        orig = ref_map[rd];
        for (int round = 0; round < 2; round++) begin
            // Two renames of the same register, both discarded at retire
            rename_one(rd, random_reg(), random_reg(), p);
            issue_one(rd, p);
            rename_one(rd, rd, random_reg(), p);
            issue_one(rd, p);
            retire_all(1'b1);
            read_check(rd, random_reg(), got);
            check_phys("phys_rs1 after suppress", orig, got);
            // Clears the restore-once bits for the second round
            flush_with_issue('0);
        end
        // Cycles the whole free list, so the freed order is checked too
        rename_issue_n(`INFLIGHT_DEPTH);
        retire_all(1'b0);
        check_map_all();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'hea9ea492));
        error_count   = 0;
        check_count   = 0;
        cycle_count   = 0;
        arst_n        = 1'b0;
        rename_req    = 1'b0;
        rd_addr       = '0;
        rs1_addr      = '0;
        rs2_addr      = '0;
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issued        = 1'b0;
        issue_rd_addr = '0;
        issue_phys_rd = '0;
        retire_valid  = 1'b0;
        suppress      = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        init_sequence();
        rename_allocation();
        commit_reuse();
        rollback_reissue();
        suppress_restore();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/rename_pkg.sv
rtl/rename_ifs.sv
rtl/rename_ctrl.sv
rtl/free_list.sv
rtl/spec_map_table.sv
rtl/inuse_list.sv
rtl/register_renamer.sv
verification/tb_register_renamer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register renamer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_register_renamer \
    -f flist.f \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
